/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

	// Major opcodes of the RV32I subset handled by the execute stage.
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // Only CSRRW and CSRRS are decoded.

	// Integer ALU funct3 codes, shared by OP and OP-IMM.
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // funct7 bit 5 picks SRA over SRL.
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	typedef enum logic [2:0] {
		FMT_R = 3'd0,
		FMT_I = 3'd1,
		FMT_S = 3'd2,
		FMT_B = 3'd3,
		FMT_U = 3'd4,
		FMT_J = 3'd5
	} fmt_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_s;

	typedef struct packed {
		logic [11:0] imm_hi;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_s;

	// The same instruction word seen as R-format fields or as an immediate form.
	typedef union packed {
		r_view_s r;
		i_view_s i;
	} inst_u;

endpackage

`default_nettype wire

/* rtl/exec_uarch_pkg.sv */
`default_nettype none

package exec_uarch_pkg;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_XOR   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_SRL   = 4'd5,
		ALU_SRA   = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_LESS  = 4'd8,
		ALU_ULESS = 4'd9
	} alu_op_e;

	// One decoded instruction as it sits in the operation queue.
	typedef struct packed {
		logic [6:0]       opcode;
		rv_isa_pkg::fmt_e fmt;
		logic [2:0]       funct3;
		alu_op_e          alu_op;
		logic [4:0]       rd;
		logic [31:0]      pc;
		logic [31:0]      src1;
		logic [31:0]      src2;
		logic [31:0]      imm;
		logic [31:0]      csr_val;
	} dec_op_s;

endpackage

`default_nettype wire

/* rtl/op_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface op_bus_if (
	input wire clk,
	input wire arst_n
);

	logic                    cyc;
	logic                    stb;
	logic                    we;
	logic                    ack;
	exec_uarch_pkg::dec_op_s dat_w; // Master to slave.
	exec_uarch_pkg::dec_op_s dat_r; // Slave to master, valid while ack is high.

	modport master (output cyc, stb, we, dat_w, input ack, dat_r);
	modport slave (input cyc, stb, we, dat_w, output ack, dat_r);

	// A slave may only answer a strobe that the master is still holding.
	ack_in_stb_a: assert property (@(posedge clk) disable iff (!arst_n) ack |-> stb);

endinterface

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  wire          clk,
	input  wire          arst_n,
	input  wire          in_cyc,
	input  wire          in_stb,
	input  wire   [31:0] in_dat_inst,
	input  wire   [31:0] in_dat_pc,
	input  wire   [31:0] in_dat_src1,
	input  wire   [31:0] in_dat_src2,
	input  wire   [31:0] in_dat_csr,
	output logic         in_ack,
	op_bus_if.master     wr_bus
);

	rv_isa_pkg::inst_u       inst;
	rv_isa_pkg::fmt_e        fmt;
	logic [31:0]             imm;
	exec_uarch_pkg::alu_op_e alu_op;

	assign inst = in_dat_inst;

	always_comb begin
		case (inst.r.opcode)
			rv_isa_pkg::OPC_LUI,
			rv_isa_pkg::OPC_AUIPC:  fmt = rv_isa_pkg::FMT_U;
			rv_isa_pkg::OPC_JAL:    fmt = rv_isa_pkg::FMT_J;
			rv_isa_pkg::OPC_BRANCH: fmt = rv_isa_pkg::FMT_B;
			rv_isa_pkg::OPC_STORE:  fmt = rv_isa_pkg::FMT_S;
			rv_isa_pkg::OPC_JALR,
			rv_isa_pkg::OPC_OP_IMM,
			rv_isa_pkg::OPC_SYSTEM: fmt = rv_isa_pkg::FMT_I;
			default:                fmt = rv_isa_pkg::FMT_R;
		endcase
	end

	// Immediates are rebuilt from the two views of the word, sign bit always at bit 31.
	always_comb begin
		case (fmt)
			rv_isa_pkg::FMT_I: imm = {{20{inst.i.imm_hi[11]}}, inst.i.imm_hi};
			rv_isa_pkg::FMT_S: imm = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rd};
			rv_isa_pkg::FMT_B: imm = {{20{inst.r.funct7[6]}}, inst.r.rd[0],
				inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
			rv_isa_pkg::FMT_U: imm = {inst.i.imm_hi, inst.i.rs1, inst.i.funct3, 12'h000};
			rv_isa_pkg::FMT_J: imm = {{12{inst.i.imm_hi[11]}}, inst.i.rs1, inst.i.funct3,
				inst.i.imm_hi[0], inst.i.imm_hi[10:1], 1'b0};
			default:           imm = 32'h0;
		endcase
	end

	always_comb begin
		alu_op = exec_uarch_pkg::ALU_ADD; // Address and link arithmetic.
		if (fmt == rv_isa_pkg::FMT_R || fmt == rv_isa_pkg::FMT_I) begin
			case (inst.i.funct3)
				rv_isa_pkg::F3_ADD:  alu_op = (fmt == rv_isa_pkg::FMT_R && inst.r.funct7[5]) ?
					exec_uarch_pkg::ALU_SUB : exec_uarch_pkg::ALU_ADD;
				rv_isa_pkg::F3_SLL:  alu_op = exec_uarch_pkg::ALU_SLL;
				rv_isa_pkg::F3_SLT:  alu_op = exec_uarch_pkg::ALU_LESS;
				rv_isa_pkg::F3_SLTU: alu_op = exec_uarch_pkg::ALU_ULESS;
				rv_isa_pkg::F3_XOR:  alu_op = exec_uarch_pkg::ALU_XOR;
				rv_isa_pkg::F3_SR:   alu_op = inst.r.funct7[5] ?
					exec_uarch_pkg::ALU_SRA : exec_uarch_pkg::ALU_SRL;
				rv_isa_pkg::F3_OR:   alu_op = exec_uarch_pkg::ALU_OR;
				rv_isa_pkg::F3_AND:  alu_op = exec_uarch_pkg::ALU_AND;
			endcase
		end
	end

	always_comb begin
		wr_bus.dat_w.opcode  = inst.r.opcode;
		wr_bus.dat_w.fmt     = fmt;
		wr_bus.dat_w.funct3  = inst.r.funct3;
		wr_bus.dat_w.alu_op  = alu_op;
		wr_bus.dat_w.rd      = inst.r.rd;
		wr_bus.dat_w.pc      = in_dat_pc;
		wr_bus.dat_w.src1    = in_dat_src1;
		wr_bus.dat_w.src2    = in_dat_src2;
		wr_bus.dat_w.imm     = imm;
		wr_bus.dat_w.csr_val = in_dat_csr;
	end

	// The queue handshake is passed straight through to the issue master.
	assign wr_bus.cyc = in_cyc;
	assign wr_bus.stb = in_stb;
	assign wr_bus.we  = 1'b1;
	assign in_ack     = wr_bus.ack;

	// The issue master must hold the packet until the queue takes it.
	dat_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
		wr_bus.stb && !wr_bus.ack |=> wr_bus.stb && $stable(wr_bus.dat_w));

endmodule

`default_nettype wire

/* rtl/op_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module op_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire      clk,
	input wire      arst_n,
	op_bus_if.slave wr_bus,
	op_bus_if.slave rd_bus
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	exec_uarch_pkg::dec_op_s mem [QUEUE_DEPTH];
	exec_uarch_pkg::dec_op_s rd_dat;
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [PTR_W:0]          count;
	logic                    wr_ack;
	logic                    rd_ack;
	logic                    wr_go;
	logic                    rd_go;

	// A transfer is taken on the strobe edge and acknowledged one cycle later.
	assign wr_go = wr_bus.cyc && wr_bus.stb && wr_bus.we && !wr_ack && (count != QUEUE_DEPTH);
	assign rd_go = rd_bus.cyc && rd_bus.stb && !rd_bus.we && !rd_ack && (count != 0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			wr_ack <= wr_go;
			rd_ack <= rd_go;
			if (wr_go)
				wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two.
			if (rd_go)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W + 1)'(wr_go) - (PTR_W + 1)'(rd_go);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go)
			mem[wr_ptr] <= wr_bus.dat_w;
		if (rd_go)
			rd_dat <= mem[rd_ptr]; // Valid in the ack cycle.
	end

	assign wr_bus.ack   = wr_ack;
	assign wr_bus.dat_r = '0;
	assign rd_bus.ack   = rd_ack;
	assign rd_bus.dat_r = rd_dat;

	// The pointers and the count move separately and must always tell the same fill level.
	ptr_count_a: assert property (@(posedge clk) disable iff (!arst_n)
		wr_ptr - rd_ptr == count[PTR_W-1:0]);
	count_range_a: assert property (@(posedge clk) disable iff (!arst_n)
		count <= QUEUE_DEPTH); // An overflow when full or an underflow when empty lands here.

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire          clk,
	input  wire          arst_n,
	op_bus_if.master     rd_bus,
	output logic         res_cyc,
	output logic         res_stb,
	output logic         res_we,
	output logic  [4:0]  res_adr,
	output logic  [31:0] res_dat,
	output logic  [31:0] res_jump,
	output logic  [31:0] res_csr_wdata,
	output logic  [3:0]  res_wmask,
	input  wire          res_ack
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE
	} state_e;

	state_e                  state;
	exec_uarch_pkg::dec_op_s op;
	logic [31:0]             lop;
	logic [31:0]             rop;
	logic [4:0]              shamt;
	logic [31:0]             val;
	logic                    jump_cond;
	logic                    jump_en;
	logic [31:0]             jump;
	logic [31:0]             csr_wdata;
	logic [3:0]              wmask;

	assign op    = rd_bus.dat_r;
	assign shamt = rop[4:0];

	always_comb begin
		case (op.opcode)
			rv_isa_pkg::OPC_LUI: lop = 32'h0;
			rv_isa_pkg::OPC_AUIPC,
			rv_isa_pkg::OPC_JAL,
			rv_isa_pkg::OPC_JALR: lop = op.pc;
			default: lop = op.src1;
		endcase
		case (op.opcode)
			rv_isa_pkg::OPC_JAL,
			rv_isa_pkg::OPC_JALR: rop = 32'd4; // Link value is pc + 4.
			rv_isa_pkg::OPC_OP: rop = op.src2;
			default: rop = op.imm;
		endcase
	end

	always_comb begin
		case (op.alu_op)
			exec_uarch_pkg::ALU_ADD:   val = lop + rop;
			exec_uarch_pkg::ALU_SUB:   val = lop - rop;
			exec_uarch_pkg::ALU_AND:   val = lop & rop;
			exec_uarch_pkg::ALU_XOR:   val = lop ^ rop;
			exec_uarch_pkg::ALU_OR:    val = lop | rop;
			exec_uarch_pkg::ALU_SRL:   val = lop >> shamt;
			exec_uarch_pkg::ALU_SRA:   val = $unsigned($signed(lop) >>> shamt);
			exec_uarch_pkg::ALU_SLL:   val = lop << shamt;
			exec_uarch_pkg::ALU_LESS:  val = {31'h0, $signed(lop) < $signed(rop)};
			exec_uarch_pkg::ALU_ULESS: val = {31'h0, lop < rop};
			default:                   val = 32'h0;
		endcase
	end

	always_comb begin
		case (op.funct3)
			rv_isa_pkg::F3_BEQ:  jump_cond = op.src1 == op.src2;
			rv_isa_pkg::F3_BNE:  jump_cond = op.src1 != op.src2;
			rv_isa_pkg::F3_BLT:  jump_cond = $signed(op.src1) < $signed(op.src2);
			rv_isa_pkg::F3_BGE:  jump_cond = $signed(op.src1) >= $signed(op.src2);
			rv_isa_pkg::F3_BLTU: jump_cond = op.src1 < op.src2;
			rv_isa_pkg::F3_BGEU: jump_cond = op.src1 >= op.src2;
			default:             jump_cond = 1'b0;
		endcase
	end

	// JALR is the only I-format jump and takes its base from src1.
	assign jump_en = (op.fmt == rv_isa_pkg::FMT_J) || (op.opcode == rv_isa_pkg::OPC_JALR) ||
		(op.fmt == rv_isa_pkg::FMT_B && jump_cond);
	assign jump = ((op.fmt == rv_isa_pkg::FMT_I ? op.src1 : op.pc) + op.imm) & {32{jump_en}};

	always_comb begin
		case (op.funct3[1:0])
			rv_isa_pkg::F3_SB[1:0]: wmask = 4'h1;
			rv_isa_pkg::F3_SH[1:0]: wmask = 4'h3;
			rv_isa_pkg::F3_SW[1:0]: wmask = 4'hf;
			default:                wmask = 4'h0;
		endcase
		case (op.funct3)
			rv_isa_pkg::F3_CSRRS: csr_wdata = op.src1 | op.csr_val;
			rv_isa_pkg::F3_CSRRW: csr_wdata = op.src1;
			default:              csr_wdata = 32'h0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: state <= ST_READ;
				ST_READ: if (rd_bus.ack) state <= ST_WRITE;
				ST_WRITE: if (res_ack) state <= ST_IDLE; // Sink may stall for any time.
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_READ && rd_bus.ack) begin
			res_adr       <= op.rd;
			res_dat       <= val;
			res_jump      <= jump;
			res_csr_wdata <= csr_wdata;
			res_wmask     <= wmask;
		end
	end

	assign rd_bus.cyc   = state == ST_READ;
	assign rd_bus.stb   = state == ST_READ;
	assign rd_bus.we    = 1'b0;
	assign rd_bus.dat_w = '0;
	assign res_cyc      = state == ST_WRITE;
	assign res_stb      = state == ST_WRITE;
	assign res_we       = state == ST_WRITE;

	res_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
		res_stb && !res_ack |=> res_stb &&
		$stable({res_adr, res_dat, res_jump, res_csr_wdata, res_wmask}));

endmodule

`default_nettype wire

/* rtl/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire          clk,
	input  wire          arst_n,
	input  wire          in_cyc,
	input  wire          in_stb,
	input  wire   [31:0] in_dat_inst,
	input  wire   [31:0] in_dat_pc,
	input  wire   [31:0] in_dat_src1,
	input  wire   [31:0] in_dat_src2,
	input  wire   [31:0] in_dat_csr,
	output logic         in_ack,
	output logic         res_cyc,
	output logic         res_stb,
	output logic         res_we,
	output logic  [4:0]  res_adr,
	output logic  [31:0] res_dat,
	output logic  [31:0] res_jump,
	output logic  [31:0] res_csr_wdata,
	output logic  [3:0]  res_wmask,
	input  wire          res_ack
);

	op_bus_if wr_bus (.clk(clk), .arst_n(arst_n)); // Decoder into the queue.
	op_bus_if rd_bus (.clk(clk), .arst_n(arst_n)); // Queue out to the execute unit.

	inst_decoder inst_decoder_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_cyc      (in_cyc),
		.in_stb      (in_stb),
		.in_dat_inst (in_dat_inst),
		.in_dat_pc   (in_dat_pc),
		.in_dat_src1 (in_dat_src1),
		.in_dat_src2 (in_dat_src2),
		.in_dat_csr  (in_dat_csr),
		.in_ack      (in_ack),
		.wr_bus      (wr_bus.master)
	);

	op_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) op_queue_i (
		.clk    (clk),
		.arst_n (arst_n),
		.wr_bus (wr_bus.slave),
		.rd_bus (rd_bus.slave)
	);

	exec_unit exec_unit_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.rd_bus        (rd_bus.master),
		.res_cyc       (res_cyc),
		.res_stb       (res_stb),
		.res_we        (res_we),
		.res_adr       (res_adr),
		.res_dat       (res_dat),
		.res_jump      (res_jump),
		.res_csr_wdata (res_csr_wdata),
		.res_wmask     (res_wmask),
		.res_ack       (res_ack)
	);

endmodule

`default_nettype wire

/* verification/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;
	localparam int N_ALU = 40;
	localparam int N_UJ = 16;
	localparam int N_BR = 24;
	localparam int N_SC = 20;
	localparam int N_FULL = 24;
	localparam int WATCHDOG_CYCLES = (N_ALU + N_UJ + N_BR + N_SC + N_FULL) * 64 + 200;

	typedef struct packed {
		logic [4:0]  adr;
		logic [31:0] dat;
		logic [31:0] jump;
		logic [31:0] csr_wdata;
		logic [3:0]  wmask;
	} res_s;

	logic        clk;
	logic        arst_n;
	logic        in_cyc;
	logic        in_stb;
	logic [31:0] in_dat_inst;
	logic [31:0] in_dat_pc;
	logic [31:0] in_dat_src1;
	logic [31:0] in_dat_src2;
	logic [31:0] in_dat_csr;
	logic        in_ack;
	logic        res_cyc;
	logic        res_stb;
	logic        res_we;
	logic [4:0]  res_adr;
	logic [31:0] res_dat;
	logic [31:0] res_jump;
	logic [31:0] res_csr_wdata;
	logic [3:0]  res_wmask;
	logic        res_ack;
	res_s        exp_q[$]; // Expected results in issue order.
	logic [31:0] rnd_state;
	logic [31:0] stall_state;
	int          issued;
	int          results;
	int          checks;
	int          errors;
	int          max_stall;
	int          max_ack_wait;

	exec_top #(.QUEUE_DEPTH(4)) exec_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift32(rnd_state);
		return rnd_state;
	endfunction

	// Expected result straight from the RV32I encoding rules.
	function automatic res_s exec_ref(input logic [31:0] inst, pc, s1, s2, csr);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic        take;
		res_s        r;
		opc = inst[6:0];
		f3 = inst[14:12];
		case (opc)
			OP_LUI, OP_AUIPC: imm = {inst[31:12], 12'h0};
			OP_JAL: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			OP_BRANCH: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			OP_STORE: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			default: imm = {{20{inst[31]}}, inst[31:20]};
		endcase
		a = (opc == OP_LUI) ? 32'h0 :
			(opc == OP_AUIPC || opc == OP_JAL || opc == OP_JALR) ? pc : s1;
		b = (opc == OP_JAL || opc == OP_JALR) ? 32'd4 : (opc == OP_REG) ? s2 : imm;
		r.dat = a + b;
		if (opc == OP_REG || opc == OP_IMM || opc == OP_JALR || opc == OP_SYSTEM) begin
			case (f3)
				3'b000: r.dat = (opc == OP_REG && inst[30]) ? a - b : a + b;
				3'b001: r.dat = a << b[4:0];
				3'b010: r.dat = {31'h0, $signed(a) < $signed(b)};
				3'b011: r.dat = {31'h0, a < b};
				3'b100: r.dat = a ^ b;
				3'b101: begin
					if (inst[30])
						r.dat = $signed(a) >>> b[4:0]; // Sign bit fills from the left.
					else
						r.dat = a >> b[4:0];
				end
				3'b110: r.dat = a | b;
				default: r.dat = a & b;
			endcase
		end
		case (f3)
			3'b000: take = s1 == s2;
			3'b001: take = s1 != s2;
			3'b100: take = $signed(s1) < $signed(s2);
			3'b101: take = $signed(s1) >= $signed(s2);
			3'b110: take = s1 < s2;
			3'b111: take = s1 >= s2;
			default: take = 1'b0;
		endcase
		r.jump = 32'h0;
		if (opc == OP_JAL || (opc == OP_BRANCH && take))
			r.jump = pc + imm;
		else if (opc == OP_JALR)
			r.jump = s1 + imm;
		r.wmask = (f3[1:0] == 2'd0) ? 4'h1 : (f3[1:0] == 2'd1) ? 4'h3 :
			(f3[1:0] == 2'd2) ? 4'hf : 4'h0;
		r.csr_wdata = (f3 == 3'b010) ? (s1 | csr) : (f3 == 3'b001) ? s1 : 32'h0;
		r.adr = inst[11:7];
		return r;
	endfunction

	// Kind 0 is OP or OP-IMM, 1 is LUI/AUIPC/JAL/JALR, 2 is branch, 3 is store or CSR.
	function automatic logic [31:0] make_inst(input int kind, input int i, input logic [31:0] r);
		logic [2:0] f3;
		case (kind)
			0: return {r[31:7], r[0] ? OP_REG : OP_IMM};
			1: case (i % 4)
				0: return {r[31:7], OP_LUI};
				1: return {r[31:7], OP_AUIPC};
				2: return {r[31:7], OP_JAL};
				default: return {r[31:15], 3'b000, r[11:7], OP_JALR};
			endcase
			2: begin
				f3 = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2); // Skips the two unused codes.
				return {r[31:15], f3, r[11:7], OP_BRANCH};
			end
			default: begin
				f3 = (i % 5 < 3) ? 3'(i % 5) : 3'(i % 5 - 2);
				return {r[31:15], f3, r[11:7], (i % 5 < 3) ? OP_STORE : OP_SYSTEM};
			end
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic issue_packet(input logic [31:0] inst, pc, s1, s2, csr);
		int wait_cycles;
		in_cyc = 1'b1;
		in_stb = 1'b1;
		in_dat_inst = inst;
		in_dat_pc = pc;
		in_dat_src1 = s1;
		in_dat_src2 = s2;
		in_dat_csr = csr;
		exp_q.push_back(exec_ref(inst, pc, s1, s2, csr));
		issued++;
		wait_cycles = 0;
		do begin
			@(posedge clk);
			#1;
			wait_cycles++;
		end while (in_ack !== 1'b1);
		if (wait_cycles > max_ack_wait)
			max_ack_wait = wait_cycles;
		@(posedge clk);
		#1;
		in_cyc = 1'b0;
		in_stb = 1'b0;
	endtask

	task automatic run_test(input string name, input int kind, input int n, input int stall);
		int          err0;
		int          res0;
		int          iss0;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] inst;
		logic [31:0] pc;
		err0 = errors;
		res0 = results;
		iss0 = issued;
		max_stall = stall;
		max_ack_wait = 0;
		for (int i = 0; i < n; i++) begin
			int k;
			k = (kind == 4) ? i % 4 : kind;
			s1 = next_rand();
			// Every other round compares equal.
			s2 = (k == 2 && (i / 6) % 2 == 1) ? s1 : next_rand();
			inst = make_inst(k, i, next_rand());
			pc = next_rand() & 32'hffff_fffc;
			issue_packet(inst, pc, s1, s2, next_rand());
		end
		while (results != issued) begin
			@(posedge clk);
			#2;
		end
		if (kind == 4 && max_ack_wait < 8) begin
			$display("Test %s: in_ack was never held back by a full queue.", name);
			errors++;
		end
		$display("Test %s: %0d issued, %0d results, %0d errors", name, issued - iss0,
			results - res0, errors - err0);
	endtask

	// Sink for the result bus, with a random stall before each ack.
	initial begin : sink
		res_s want;
		int   stall;
		forever begin
			@(posedge clk);
			#1;
			if (res_stb === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("A result arrived with no instruction outstanding.");
					errors++;
				end else begin
					want = exp_q.pop_front();
					check_val("res_cyc", 32'(res_cyc), 32'h1);
					check_val("res_we", 32'(res_we), 32'h1);
					check_val("res_adr", 32'(res_adr), 32'(want.adr));
					check_val("res_dat", res_dat, want.dat);
					check_val("res_jump", res_jump, want.jump);
					check_val("res_csr_wdata", res_csr_wdata, want.csr_wdata);
					check_val("res_wmask", 32'(res_wmask), 32'(want.wmask));
				end
				stall_state = xorshift32(stall_state);
				stall = (max_stall > 0) ? int'(stall_state[15:0]) % max_stall : 0;
				repeat (stall) begin
					@(posedge clk);
					#1;
				end
				res_ack = 1'b1;
				@(posedge clk);
				#1;
				res_ack = 1'b0;
				results++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the DUT stopped taking instructions or returning results.");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		in_cyc = 1'b0;
		in_stb = 1'b0;
		in_dat_inst = 32'h0;
		in_dat_pc = 32'h0;
		in_dat_src1 = 32'h0;
		in_dat_src2 = 32'h0;
		in_dat_csr = 32'h0;
		res_ack = 1'b0;
		rnd_state = 32'h88d8_2368;
		stall_state = xorshift32(~32'h88d8_2368); // Separate stream for the sink.
		repeat (8) @(posedge clk);
		#1 arst_n = 1'b1;
		repeat (6) begin
			@(posedge clk);
			#1;
			check_val("in_ack", 32'(in_ack), 32'h0);
			check_val("res_stb", 32'(res_stb), 32'h0);
		end
		$display("Test reset: %0d errors", errors);
		run_test("alu", 0, N_ALU, 4);
		run_test("upper_jump", 1, N_UJ, 4);
		run_test("branch", 2, N_BR, 4);
		run_test("store_csr", 3, N_SC, 4);
		run_test("full_queue", 4, N_FULL, 40);
		repeat (4) @(posedge clk);
		$display("Summary: %0d issued, %0d results, %0d checks, %0d errors", issued, results,
			checks, errors);
		if (errors == 0 && results == issued && exp_q.size() == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/rv_isa_pkg.sv
rtl/exec_uarch_pkg.sv
rtl/op_bus_if.sv
rtl/inst_decoder.sv
rtl/op_queue.sv
rtl/exec_unit.sv
rtl/exec_top.sv
verification/exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it, and scans the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module exec_tb \
	-Mdir obj_dir -o exec_tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed."; exit 1; }
./obj_dir/exec_tb_sim > sim.log 2>&1; cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure."; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without a result."; exit 1; }
exit 0
